//--- logic/sportPkg.sv
package sportPkg;

  localparam int DataWidth = 16;
  localparam int AxiAddrWidth = 8;
  localparam int AxiDataWidth = 32;
  localparam int RegIdxWidth = 3;
  localparam int SlenWidth = 5;
  localparam int FrameCntWidth = 4;

  // byte offsets inside one port window
  localparam int RegAuto = 'h00;
  localparam int RegFsdiv = 'h04;
  localparam int RegSclkdiv = 'h08;
  localparam int RegSctl = 'h0C;
  localparam int RegMword = 'h10;

  localparam int PortStride = 'h20;
  localparam int BufBase = 'h40;

  // AC97 preset, MWORD kept as {bits 15:13, bits 7:0}
  localparam logic [15:0] Ac97Fsdiv = 16'd255;
  localparam logic [15:0] Ac97Sctl = 16'h010F;
  localparam logic [10:0] Ac97Mword = 11'h210;

  localparam int SctlIrfs = 8;
  localparam int SctlSlenHi = 3;
  localparam int SctlSlenLo = 0;
  localparam int MwordSlenExt = 15;
  localparam int MwordAc97 = 14;
  localparam int AutoClr = 13;

endpackage

//--- logic/axiLiteRegPort.sv
module axiLiteRegPort import sportPkg::*;
#(
  parameter int BufDepth = 8
)
(
  input  logic                          DSPCLK,
  input  logic                          RST,
  input  logic                          awvalid,
  input  logic [AxiAddrWidth-1:0]       awaddr,
  input  logic                          wvalid,
  input  logic [AxiDataWidth-1:0]       wdata,
  input  logic [AxiDataWidth/8-1:0]     wstrb,
  input  logic                          bready,
  input  logic                          arvalid,
  input  logic [AxiAddrWidth-1:0]       araddr,
  input  logic                          rready,
  output logic                          awready,
  output logic                          wready,
  output logic                          bvalid,
  output logic [1:0]                    bresp,
  output logic                          arready,
  output logic                          rvalid,
  output logic [AxiDataWidth-1:0]       rdata,
  output logic [1:0]                    rresp,
  input  logic [DataWidth-1:0]          rdData0,
  input  logic [DataWidth-1:0]          rdData1,
  input  logic [DataWidth-1:0]          bufRdData,
  output logic [DataWidth-1:0]          wrData,
  output logic                          wrEn0,
  output logic                          wrEn1,
  output logic [RegIdxWidth-1:0]        regIdx,
  output logic [$clog2(2*BufDepth)-1:0] bufRdAddr
);

  localparam int BufAddrWidth = $clog2(2*BufDepth);

  logic wrSet;
  logic rdSet;
  logic wrDone;
  logic rdDone;
  logic rdIsBuf;
  logic [AxiAddrWidth-1:0] bufOff;
  logic [DataWidth-1:0] rdSel;

  // write wins a tie so the shared register index stays unambiguous
  assign wrSet = awvalid && wvalid && !awready && !bvalid;
  assign rdSet = arvalid && !arready && !rvalid && !wrSet;
  assign wrDone = awready && awvalid && wvalid;
  assign rdDone = arready && arvalid;

  assign wrData = wdata[DataWidth-1:0];
  assign wrEn0 = wrDone && (awaddr < PortStride);
  assign wrEn1 = wrDone && (awaddr >= PortStride) && (awaddr < 2*PortStride);
  assign regIdx = awready ? awaddr[RegIdxWidth+1:2] : araddr[RegIdxWidth+1:2];

  assign bufOff = araddr - AxiAddrWidth'(BufBase);
  assign rdIsBuf = (araddr >= BufBase) && (bufOff < 8*BufDepth);
  assign bufRdAddr = bufOff[BufAddrWidth+1:2];

  always_comb
  begin
    if (araddr < PortStride)
      rdSel = rdData0;
    else if (araddr < 2*PortStride)
      rdSel = rdData1;
    else if (rdIsBuf)
      rdSel = bufRdData;
    else
      rdSel = '0;
  end

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      awready <= 1'b0;
      wready <= 1'b0;
      arready <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      awready <= wrSet;
      wready <= wrSet;
      arready <= rdSet;
      if (wrDone)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (rdDone)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    if (rdDone)
      rdata <= {{(AxiDataWidth-DataWidth){1'b0}}, rdSel};
  end

endmodule

//--- logic/sportCtrlRegs.sv
module sportCtrlRegs import sportPkg::*;
(
  input  logic                     DSPCLK,
  input  logic                     RST,
  input  logic [DataWidth-1:0]     wrData,
  input  logic                     wrEn,
  input  logic [RegIdxWidth-1:0]   regIdx,
  input  logic [FrameCntWidth-1:0] frameCount,
  output logic [DataWidth-1:0]     rdData,
  output logic [DataWidth-1:0]     sclkDiv,
  output logic [DataWidth-1:0]     fsDiv,
  output logic                     irfsEn,
  output logic [SlenWidth-1:0]     slen,
  output logic                     idxClr
);

  localparam logic [RegIdxWidth-1:0] IdxAuto = RegIdxWidth'(RegAuto / 4);
  localparam logic [RegIdxWidth-1:0] IdxFsdiv = RegIdxWidth'(RegFsdiv / 4);
  localparam logic [RegIdxWidth-1:0] IdxSclkdiv = RegIdxWidth'(RegSclkdiv / 4);
  localparam logic [RegIdxWidth-1:0] IdxSctl = RegIdxWidth'(RegSctl / 4);
  localparam logic [RegIdxWidth-1:0] IdxMword = RegIdxWidth'(RegMword / 4);

  logic [DataWidth-1:0] autoReg;
  logic [DataWidth-1:0] sctlReg;
  logic [10:0] mwStore;
  logic [DataWidth-1:0] mword;
  logic [DataWidth-1:0] mwordRd;
  logic [DataWidth-1:0] autoRd;
  logic wrAuto;
  logic wrFsdiv;
  logic wrSclkdiv;
  logic wrSctl;
  logic wrMword;
  logic acPreset;

  assign wrAuto = wrEn && (regIdx == IdxAuto);
  assign wrFsdiv = wrEn && (regIdx == IdxFsdiv);
  assign wrSclkdiv = wrEn && (regIdx == IdxSclkdiv);
  assign wrSctl = wrEn && (regIdx == IdxSctl);
  assign wrMword = wrEn && (regIdx == IdxMword);

  // bit 14 of an MWORD write loads the AC97 preset
  assign acPreset = wrMword && wrData[MwordAc97];

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      autoReg <= '0;
      fsDiv <= '0;
      sclkDiv <= '0;
      sctlReg <= '0;
      mwStore <= '0;
    end
    else
    begin
      if (wrAuto)
        autoReg <= wrData;
      else
        autoReg[AutoClr] <= 1'b0;
      if (acPreset)
        fsDiv <= Ac97Fsdiv;
      else if (wrFsdiv)
        fsDiv <= wrData;
      if (wrSclkdiv)
        sclkDiv <= wrData;
      if (acPreset)
        sctlReg <= Ac97Sctl;
      else if (wrSctl)
        sctlReg <= wrData;
      if (acPreset)
        mwStore <= Ac97Mword | {2'b00, wrData[13], 8'h00};
      else if (wrMword)
        mwStore <= {wrData[15:13], wrData[7:0]};
    end
  end

  assign mword = {mwStore[10:8], 5'b00000, mwStore[7:0]};

  // live frame count shows only in preset mode
  always_comb
  begin
    mwordRd = mword;
    if (mword[MwordAc97])
      mwordRd[11:8] = frameCount;
  end

  always_comb
  begin
    autoRd = autoReg;
    autoRd[AutoClr] = 1'b0;
  end

  always_comb
  begin
    case (regIdx)
      IdxAuto: rdData = autoRd;
      IdxFsdiv: rdData = fsDiv;
      IdxSclkdiv: rdData = sclkDiv;
      IdxSctl: rdData = sctlReg;
      IdxMword: rdData = mwordRd;
      default: rdData = '0;
    endcase
  end

  assign irfsEn = sctlReg[SctlIrfs];
  assign slen = {mword[MwordSlenExt], sctlReg[SctlSlenHi:SctlSlenLo]};
  assign idxClr = autoReg[AutoClr];

endmodule

//--- logic/sportClockGen.sv
module sportClockGen import sportPkg::*;
(
  input  logic                 DSPCLK,
  input  logic                 RST,
  input  logic [DataWidth-1:0] sclkDiv,
  input  logic [DataWidth-1:0] fsDiv,
  input  logic                 irfsEn,
  output logic                 sclk,
  output logic                 sclkRise,
  output logic                 rfs
);

  logic [DataWidth-1:0] divCnt;
  logic [DataWidth-1:0] frameCnt;
  logic divHit;

  assign divHit = (divCnt == sclkDiv);

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      divCnt <= '0;
      frameCnt <= '0;
      sclk <= 1'b0;
      sclkRise <= 1'b0;
      rfs <= 1'b0;
    end
    else if (!irfsEn)
    begin
      divCnt <= '0;
      frameCnt <= '0;
      sclk <= 1'b0;
      sclkRise <= 1'b0;
      rfs <= 1'b0;
    end
    else
    begin
      sclkRise <= divHit && !sclk;
      if (divHit)
      begin
        divCnt <= '0;
        sclk <= !sclk;
        // rfs moves on the falling edge so it is stable at the next rise
        if (sclk)
        begin
          if (frameCnt == fsDiv)
          begin
            frameCnt <= '0;
            rfs <= 1'b1;
          end
          else
          begin
            frameCnt <= frameCnt + 1'b1;
            rfs <= 1'b0;
          end
        end
      end
      else
        divCnt <= divCnt + 1'b1;
    end
  end

endmodule

//--- logic/sportReceiver.sv
module sportReceiver import sportPkg::*;
(
  input  logic                     DSPCLK,
  input  logic                     RST,
  input  logic                     sclkRise,
  input  logic                     rfs,
  input  logic                     dr,
  input  logic [SlenWidth-1:0]     slen,
  output logic                     rxValid,
  output logic [DataWidth-1:0]     rxWord,
  output logic [FrameCntWidth-1:0] frameCount
);

  logic busy;
  logic [SlenWidth-1:0] remain;
  logic [DataWidth-1:0] shiftReg;
  logic [DataWidth-1:0] sampled;
  logic take;
  logic last;

  // a new word starts right-justified from zero
  assign sampled = busy ? {shiftReg[DataWidth-2:0], dr} : {{(DataWidth-1){1'b0}}, dr};
  assign take = sclkRise && (busy || rfs);
  assign last = busy ? (remain == 1) : (slen == 0);

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      busy <= 1'b0;
      remain <= '0;
      rxValid <= 1'b0;
      frameCount <= '0;
    end
    else
    begin
      rxValid <= take && last;
      if (take)
      begin
        remain <= busy ? remain - 1'b1 : slen;
        busy <= !last;
        if (last)
          frameCount <= frameCount + 1'b1;
      end
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    if (take)
      shiftReg <= sampled;
    if (take && last)
      rxWord <= sampled;
  end

endmodule

//--- logic/rxBufferArbiter.sv
module rxBufferArbiter import sportPkg::*;
#(
  parameter int BufDepth = 8
)
(
  input  logic                          DSPCLK,
  input  logic                          RST,
  input  logic                          rxValid0,
  input  logic [DataWidth-1:0]          rxWord0,
  input  logic                          idxClr0,
  input  logic                          rxValid1,
  input  logic [DataWidth-1:0]          rxWord1,
  input  logic                          idxClr1,
  output logic                          bufWrEn,
  output logic [$clog2(2*BufDepth)-1:0] bufWrAddr,
  output logic [DataWidth-1:0]          bufWrData
);

  localparam int IdxWidth = $clog2(BufDepth);

  logic [1:0] rxValid;
  logic [1:0] idxClr;
  logic [1:0] pend;
  logic [1:0] grant;
  logic [DataWidth-1:0] rxWord [2];
  logic [DataWidth-1:0] word [2];
  logic [IdxWidth-1:0] wrIdx [2];
  logic lastGrant;

  assign rxValid = {rxValid1, rxValid0};
  assign idxClr = {idxClr1, idxClr0};
  assign rxWord[0] = rxWord0;
  assign rxWord[1] = rxWord1;

  // on a tie the port not served last goes first
  assign grant = (&pend) ? (lastGrant ? 2'b01 : 2'b10) : pend;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      pend <= '0;
      wrIdx[0] <= '0;
      wrIdx[1] <= '0;
      lastGrant <= 1'b1;
      bufWrEn <= 1'b0;
    end
    else
    begin
      for (int p = 0; p < 2; p++)
      begin
        if (rxValid[p])
          pend[p] <= 1'b1;
        else if (grant[p])
          pend[p] <= 1'b0;
        if (idxClr[p])
          wrIdx[p] <= '0;
        else if (grant[p])
          wrIdx[p] <= wrIdx[p] + 1'b1;
      end
      bufWrEn <= |grant;
      if (|grant)
        lastGrant <= grant[1];
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    for (int p = 0; p < 2; p++)
    begin
      if (rxValid[p])
        word[p] <= rxWord[p];
    end
    if (|grant)
    begin
      bufWrAddr <= {grant[1], wrIdx[grant[1]]};
      bufWrData <= word[grant[1]];
    end
  end

endmodule

//--- logic/rxBuffer.sv
module rxBuffer import sportPkg::*;
#(
  parameter int BufDepth = 8
)
(
  input  logic                          DSPCLK,
  input  logic                          bufWrEn,
  input  logic [$clog2(2*BufDepth)-1:0] bufWrAddr,
  input  logic [DataWidth-1:0]          bufWrData,
  input  logic [$clog2(2*BufDepth)-1:0] bufRdAddr,
  output logic [DataWidth-1:0]          bufRdData
);

  // port 0 in the lower half, port 1 in the upper half
  logic [DataWidth-1:0] mem [2*BufDepth];

  always_ff @(posedge DSPCLK)
  begin
    if (bufWrEn)
      mem[bufWrAddr] <= bufWrData;
  end

  assign bufRdData = mem[bufRdAddr];

endmodule

//--- logic/sportSubsys.sv
module sportSubsys import sportPkg::*;
(
  input  logic                      DSPCLK,
  input  logic                      RST,
  input  logic                      awvalid,
  input  logic [AxiAddrWidth-1:0]   awaddr,
  input  logic                      wvalid,
  input  logic [AxiDataWidth-1:0]   wdata,
  input  logic [AxiDataWidth/8-1:0] wstrb,
  input  logic                      bready,
  input  logic                      arvalid,
  input  logic [AxiAddrWidth-1:0]   araddr,
  input  logic                      rready,
  input  logic                      dr0,
  input  logic                      dr1,
  output logic                      awready,
  output logic                      wready,
  output logic                      bvalid,
  output logic [1:0]                bresp,
  output logic                      arready,
  output logic                      rvalid,
  output logic [AxiDataWidth-1:0]   rdata,
  output logic [1:0]                rresp,
  output logic                      sclk0,
  output logic                      sclk1,
  output logic                      rfs0,
  output logic                      rfs1
);

  localparam int BufDepth = 8;
  localparam int BufAddrWidth = $clog2(2*BufDepth);

  logic [DataWidth-1:0] wrData;
  logic [RegIdxWidth-1:0] regIdx;
  logic [1:0] wrEn;
  logic [DataWidth-1:0] rdData [2];
  logic [BufAddrWidth-1:0] bufRdAddr;
  logic [DataWidth-1:0] bufRdData;
  logic bufWrEn;
  logic [BufAddrWidth-1:0] bufWrAddr;
  logic [DataWidth-1:0] bufWrData;

  logic [DataWidth-1:0] sclkDiv [2];
  logic [DataWidth-1:0] fsDiv [2];
  logic [SlenWidth-1:0] slen [2];
  logic [DataWidth-1:0] rxWord [2];
  logic [FrameCntWidth-1:0] frameCount [2];
  logic [1:0] irfsEn;
  logic [1:0] idxClr;
  logic [1:0] sclkRise;
  logic [1:0] sclk;
  logic [1:0] rfs;
  logic [1:0] dr;
  logic [1:0] rxValid;

  assign dr = {dr1, dr0};
  assign sclk0 = sclk[0];
  assign sclk1 = sclk[1];
  assign rfs0 = rfs[0];
  assign rfs1 = rfs[1];

  axiLiteRegPort #(.BufDepth(BufDepth)) busPort (
    .DSPCLK(DSPCLK), .RST(RST),
    .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb),
    .bready(bready), .arvalid(arvalid), .araddr(araddr), .rready(rready),
    .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
    .arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
    .rdData0(rdData[0]), .rdData1(rdData[1]), .bufRdData(bufRdData),
    .wrData(wrData), .wrEn0(wrEn[0]), .wrEn1(wrEn[1]), .regIdx(regIdx),
    .bufRdAddr(bufRdAddr)
  );

  for (genvar p = 0; p < 2; p++)
  begin : portGen
    sportCtrlRegs ctrlRegs (
      .DSPCLK(DSPCLK), .RST(RST), .wrData(wrData), .wrEn(wrEn[p]), .regIdx(regIdx),
      .frameCount(frameCount[p]), .rdData(rdData[p]), .sclkDiv(sclkDiv[p]),
      .fsDiv(fsDiv[p]), .irfsEn(irfsEn[p]), .slen(slen[p]), .idxClr(idxClr[p])
    );

    sportClockGen clockGen (
      .DSPCLK(DSPCLK), .RST(RST), .sclkDiv(sclkDiv[p]), .fsDiv(fsDiv[p]),
      .irfsEn(irfsEn[p]), .sclk(sclk[p]), .sclkRise(sclkRise[p]), .rfs(rfs[p])
    );

    sportReceiver receiver (
      .DSPCLK(DSPCLK), .RST(RST), .sclkRise(sclkRise[p]), .rfs(rfs[p]), .dr(dr[p]),
      .slen(slen[p]), .rxValid(rxValid[p]), .rxWord(rxWord[p]),
      .frameCount(frameCount[p])
    );
  end

  rxBufferArbiter #(.BufDepth(BufDepth)) arbiter (
    .DSPCLK(DSPCLK), .RST(RST),
    .rxValid0(rxValid[0]), .rxWord0(rxWord[0]), .idxClr0(idxClr[0]),
    .rxValid1(rxValid[1]), .rxWord1(rxWord[1]), .idxClr1(idxClr[1]),
    .bufWrEn(bufWrEn), .bufWrAddr(bufWrAddr), .bufWrData(bufWrData)
  );

  rxBuffer #(.BufDepth(BufDepth)) buffer (
    .DSPCLK(DSPCLK), .bufWrEn(bufWrEn), .bufWrAddr(bufWrAddr), .bufWrData(bufWrData),
    .bufRdAddr(bufRdAddr), .bufRdData(bufRdData)
  );

endmodule

//--- dv/sportTb.sv
module sportTb import sportPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BufDepth = 8;
  localparam int Limit = 20000;

  logic DSPCLK;
  logic RST;
  logic awvalid;
  logic [7:0] awaddr;
  logic wvalid;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic bready;
  logic arvalid;
  logic [7:0] araddr;
  logic rready;
  logic dr0;
  logic dr1;
  logic awready;
  logic wready;
  logic bvalid;
  logic [1:0] bresp;
  logic arready;
  logic rvalid;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic sclk0;
  logic sclk1;
  logic rfs0;
  logic rfs1;

  logic [31:0] lcgState = 32'd59;
  int slenCfg [2] = '{11, 11};
  logic [31:0] curWord [2];
  int bitPos [2] = '{0, 0};
  bit active [2] = '{0, 0};
  int doneCount [2] = '{0, 0};
  logic nextBit [2] = '{1'b0, 1'b0};
  logic sclkPrev [2] = '{1'b0, 1'b0};
  logic rfsPrev [2] = '{1'b0, 1'b0};
  logic [15:0] expMem [2*BufDepth];
  bit expValid [2*BufDepth];
  int expIdx [2] = '{0, 0};
  logic [15:0] rd;

  sportSubsys dut_i (.*);

  initial
  begin
    DSPCLK = 1'b0;
    forever #4 DSPCLK = ~DSPCLK;
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // low 16 bits of the slen+1 bits sent
  function automatic logic [15:0] expWord(input logic [31:0] bits, input int slen);
    logic [31:0] mask;
    mask = (32'd1 << (slen + 1)) - 32'd1;
    return 16'(bits & mask);
  endfunction

  // serial source, MSB on rfs rise, next bit on each sclk fall
  always @(negedge DSPCLK)
  begin
    logic [1:0] sclkNow;
    logic [1:0] rfsNow;
    int e;
    sclkNow = {sclk1, sclk0};
    rfsNow = {rfs1, rfs0};
    for (int p = 0; p < 2; p++)
    begin
      if (rfsNow[p] && !rfsPrev[p])
      begin
        curWord[p] = lcgNext();
        bitPos[p] = slenCfg[p];
        active[p] = 1'b1;
        nextBit[p] = curWord[p][slenCfg[p]];
      end
      else if (active[p] && sclkPrev[p] && !sclkNow[p])
      begin
        if (bitPos[p] == 0)
        begin
          // last bit was sampled, so the word is now in the DUT
          active[p] = 1'b0;
          e = p * BufDepth + expIdx[p];
          expMem[e] = expWord(curWord[p], slenCfg[p]);
          expValid[e] = 1'b1;
          expIdx[p] = (expIdx[p] + 1) % BufDepth;
          doneCount[p]++;
        end
        else
        begin
          bitPos[p]--;
          nextBit[p] = curWord[p][bitPos[p]];
        end
      end
      sclkPrev[p] = sclkNow[p];
      rfsPrev[p] = rfsNow[p];
    end
  end

  always @(posedge DSPCLK)
  begin
    dr0 <= nextBit[0];
    dr1 <= nextBit[1];
  end

  task automatic timeoutFail(input string what);
    $display("timeout while waiting for %s", what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp)
    else
    begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic axiWrite(input logic [7:0] addr, input logic [15:0] data);
    int n;
    @(posedge DSPCLK);
    awvalid <= 1'b1;
    awaddr <= addr;
    wvalid <= 1'b1;
    wdata <= {16'h0000, data};
    n = 0;
    do
    begin
      @(negedge DSPCLK);
      n++;
    end
    while (!awready && n < Limit);
    if (!awready)
      timeoutFail("awready");
    checkEq("wready with awready", 16'h0001, 16'(wready));
    @(posedge DSPCLK);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    bready <= 1'b1;
    n = 0;
    do
    begin
      @(negedge DSPCLK);
      n++;
    end
    while (!bvalid && n < Limit);
    if (!bvalid)
      timeoutFail("bvalid");
    checkEq("bresp", 16'h0000, 16'(bresp));
    @(posedge DSPCLK);
    bready <= 1'b0;
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [15:0] data);
    int n;
    @(posedge DSPCLK);
    arvalid <= 1'b1;
    araddr <= addr;
    n = 0;
    do
    begin
      @(negedge DSPCLK);
      n++;
    end
    while (!arready && n < Limit);
    if (!arready)
      timeoutFail("arready");
    @(posedge DSPCLK);
    arvalid <= 1'b0;
    rready <= 1'b1;
    n = 0;
    do
    begin
      @(negedge DSPCLK);
      n++;
    end
    while (!rvalid && n < Limit);
    if (!rvalid)
      timeoutFail("rvalid");
    checkEq("rresp", 16'h0000, 16'(rresp));
    checkEq("rdata upper bits", 16'h0000, rdata[31:16]);
    data = rdata[15:0];
    @(posedge DSPCLK);
    rready <= 1'b0;
  endtask

  task automatic readCheck(input string name, input logic [7:0] addr, input logic [15:0] exp);
    logic [15:0] act;
    axiRead(addr, act);
    checkEq(name, exp, act);
  endtask

  task automatic checkBuffer(input string name);
    for (int e = 0; e < 2 * BufDepth; e++)
    begin
      if (expValid[e])
        readCheck(name, 8'(BufBase + 4 * e), expMem[e]);
    end
  endtask

  task automatic waitFrames(input int target0, input int target1);
    int n;
    n = 0;
    while ((doneCount[0] < target0 || doneCount[1] < target1) && n < Limit)
    begin
      @(negedge DSPCLK);
      n++;
    end
    if (doneCount[0] < target0 || doneCount[1] < target1)
      timeoutFail("received frames");
  endtask

  // everything except SCTL, which starts the port
  task automatic setupPort(input int p, input logic [15:0] sclkDiv, input logic [15:0] fsDiv,
                           input logic [15:0] mword, input int slen);
    slenCfg[p] = slen;
    axiWrite(8'(p * PortStride + RegSclkdiv), sclkDiv);
    axiWrite(8'(p * PortStride + RegFsdiv), fsDiv);
    axiWrite(8'(p * PortStride + RegMword), mword);
  endtask

  initial
  begin
    RST <= 1'b1;
    awvalid <= 1'b0;
    awaddr <= '0;
    wvalid <= 1'b0;
    wdata <= '0;
    wstrb <= 4'hF;
    bready <= 1'b0;
    arvalid <= 1'b0;
    araddr <= '0;
    rready <= 1'b0;
    dr0 <= 1'b0;
    dr1 <= 1'b0;
    repeat (8) @(posedge DSPCLK);
    RST <= 1'b0;

    for (int p = 0; p < 2; p++)
    begin
      axiWrite(8'(p * PortStride + RegFsdiv), 16'h0150 + 16'(p));
      axiWrite(8'(p * PortStride + RegSclkdiv), 16'h3C00 + 16'(p));
      axiWrite(8'(p * PortStride + RegSctl), 16'h20F0 + 16'(p));
      axiWrite(8'(p * PortStride + RegAuto), 16'h1234 + 16'(p));
    end
    for (int p = 0; p < 2; p++)
    begin
      readCheck("fsdiv readback", 8'(p * PortStride + RegFsdiv), 16'h0150 + 16'(p));
      readCheck("sclkdiv readback", 8'(p * PortStride + RegSclkdiv), 16'h3C00 + 16'(p));
      readCheck("sctl readback", 8'(p * PortStride + RegSctl), 16'h20F0 + 16'(p));
      readCheck("auto readback", 8'(p * PortStride + RegAuto), 16'h1234 + 16'(p));
      axiRead(8'(p * PortStride + RegMword), rd);
      checkEq("mword status bits", 16'h0000, rd & 16'h1F00);
    end

    // preset with bit 13 also written
    axiWrite(8'(PortStride + RegMword), 16'h6000);
    readCheck("ac97 fsdiv", 8'(PortStride + RegFsdiv), Ac97Fsdiv);
    readCheck("ac97 sctl", 8'(PortStride + RegSctl), Ac97Sctl);
    readCheck("ac97 mword", 8'(PortStride + RegMword),
              {Ac97Mword[10:8] | 3'b001, 5'b00000, Ac97Mword[7:0]});
    axiWrite(8'(PortStride + RegSctl), 16'h0000);
    axiWrite(8'(PortStride + RegMword), 16'h0000);

    setupPort(0, 16'd1, 16'd20, 16'h0000, 11);
    axiWrite(8'(RegSctl), 16'h010B);
    waitFrames(4, 0);
    axiWrite(8'(RegSctl), 16'h0000);
    checkBuffer("single port");

    // extension bit plus code 3 gives 20 bits
    setupPort(0, 16'd1, 16'd30, 16'h8000, 19);
    axiWrite(8'(RegSctl), 16'h0103);
    waitFrames(5, 0);
    axiWrite(8'(RegSctl), 16'h0000);
    axiWrite(8'(RegMword), 16'h0000);
    checkBuffer("long word");

    setupPort(0, 16'd1, 16'd20, 16'h0000, 11);
    setupPort(1, 16'd1, 16'd20, 16'h0000, 11);
    axiWrite(8'(RegSctl), 16'h010B);
    // one frame of 2*2*21 clocks less one write puts port 1 in step with port 0
    repeat (2 * 2 * 21 - 4) @(posedge DSPCLK);
    axiWrite(8'(PortStride + RegSctl), 16'h010B);
    waitFrames(5 + BufDepth + 2, BufDepth + 1);
    axiWrite(8'(RegSctl), 16'h0000);
    axiWrite(8'(PortStride + RegSctl), 16'h0000);
    checkBuffer("shared buffer");

    axiWrite(8'(RegAuto), 16'h2000);
    expIdx[0] = 0;
    readCheck("auto self clear", 8'(RegAuto), 16'h0000);
    axiWrite(8'(RegSctl), 16'h010B);
    waitFrames(5 + BufDepth + 4, BufDepth + 1);
    axiWrite(8'(RegSctl), 16'h0000);
    checkBuffer("index clear");

    // frame count shows in MWORD once the preset is on
    axiWrite(8'(RegMword), 16'h4000);
    readCheck("frame count", 8'(RegMword),
              {Ac97Mword[10:8], 1'b0, 4'(doneCount[0]), Ac97Mword[7:0]});

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verilog.f
logic/sportPkg.sv
logic/axiLiteRegPort.sv
logic/sportCtrlRegs.sv
logic/sportClockGen.sv
logic/sportReceiver.sv
logic/rxBufferArbiter.sv
logic/rxBuffer.sv
logic/sportSubsys.sv
dv/sportTb.sv
